// File: design/syncTxPkg.sv
// Command word views and union, special characters, CRC constants, line limit

package syncTxPkg;

   ////////////////////
   // Line limits
   ////////////////////

   // Width of the clear mask, so also the most lines a build can have
   localparam int maxLines = 4;

   ////////////////////
   // Command encodings
   ////////////////////

   // Top two bits of every command word
   typedef enum logic [1:0] {
      opChar  = 2'd0,
      opClear = 2'd1,
      opNone  = 2'd2
   } txOp;

   // What a character command puts on the line
   typedef enum logic [1:0] {
      kindData  = 2'd0,
      kindFlag  = 2'd1,
      kindAbort = 2'd2
   } txCharKind;

   // Send one character on one line
   typedef struct packed {
      txOp          op;
      logic [1:0]   chan;
      txCharKind    kind;
      logic         zbi;
      logic         pad;
      logic [7:0]   data;
   } txCharView;

   // Clear a set of lines
   typedef struct packed {
      txOp                  op;
      logic [1:0]           pad0;
      logic [maxLines-1:0]  clearMask;
      logic [7:0]           pad1;
   } txCtrlView;

   // Same 16 bits, read through whichever view op selects
   typedef union packed {
      txCharView charView;
      txCtrlView ctrlView;
   } txCommand;

   ////////////////////
   // Special characters
   ////////////////////

   localparam logic [7:0] charFlag  = 8'b0111_1110;
   localparam logic [7:0] charAbort = 8'b1111_1111;

   ////////////////////
   // CRC-CCITT
   ////////////////////

   localparam logic [15:0] crcPoly = 16'h1021;
   localparam logic [15:0] crcInit = 16'hFFFF;

endpackage

// File: design/usrtChanIf.sv
// Interface for one transmit line: dispatcher controls, transmitter status, CRC tap

`timescale 1ns/1ps

interface usrtChanIf;

   // Controls from the dispatcher, load and clr are one-cycle pulses
   logic       load;
   logic       abort;
   logic       flag;
   logic       zbi;
   logic [7:0] data;
   logic       clr;

   // Status and serial data from the transmitter
   logic       txd;
   logic       crcen;      // Low while a stuffed zero is on txd
   logic       empty;
   logic       sending;

   // Dispatcher side
   modport feed (
      output load, abort, flag, zbi, data, clr,
      input  empty
   );

   // Transmitter side
   modport line (
      input  load, abort, flag, zbi, data, clr,
      output txd, crcen, empty, sending
   );

   // CRC bank only watches
   modport tap (
      input txd, crcen, sending, clr
   );

endinterface

// File: design/txDispatch.sv
// Bit-rate strobe generator and command decoder driving the transmit lines

`timescale 1ns/1ps

module txDispatch #(
   parameter int numLines = 4,
   parameter int clkDiv   = 4
) (
   input  logic                clk,
   input  logic                rst,
   input  logic                cmdValid,
   input  syncTxPkg::txCommand cmdWord,
   output logic                bitStrobe,
   output logic                cmdReject,
   usrtChanIf.feed             lines [numLines]
);

   localparam int divW = $clog2(clkDiv);

   ////////////////////
   // Bit-rate strobe
   ////////////////////

   logic [divW-1:0] divCnt;

   // Free-running divider, restarts from zero at reset
   always_ff @(posedge clk)
   begin
      if (rst)
         divCnt <= '0;
      else if (divCnt == divW'(clkDiv - 1))
         divCnt <= '0;
      else
         divCnt <= divCnt + 1'b1;
   end

   // One clock in every clkDiv, never in the first cycle after reset
   assign bitStrobe = (divCnt == divW'(clkDiv - 1));

   ////////////////////
   // Command decode
   ////////////////////

   logic [syncTxPkg::maxLines-1:0] lineEmpty;
   logic [numLines-1:0]            loadNext;
   logic [numLines-1:0]            clrNext;
   logic                           rejectNext;
   logic                           charAccept;
   logic [numLines-1:0]            loadR;
   logic [numLines-1:0]            clrR;
   logic                           abortR;
   logic                           flagR;
   logic                           zbiR;
   logic [7:0]                     dataR;

   // Lines above numLines read as busy, so chan out of range is rejected
   assign charAccept = lineEmpty[cmdWord.charView.chan];

   always_comb
   begin
      loadNext   = '0;
      clrNext    = '0;
      rejectNext = 1'b0;
      if (cmdValid)
      begin
         // op sits in the same bits of both views
         case (cmdWord.charView.op)
            syncTxPkg::opChar:
            begin
               for (int i = 0; i < numLines; i++)
                  loadNext[i] = charAccept && (cmdWord.charView.chan == i);
               rejectNext = !charAccept;
            end
            syncTxPkg::opClear:
            begin
               // Mask bits for absent lines are dropped
               for (int i = 0; i < numLines; i++)
                  clrNext[i] = cmdWord.ctrlView.clearMask[i];
            end
            default:
            begin
               // opNone and unused codes do nothing
               rejectNext = 1'b0;
            end
         endcase
      end
   end

   // Pulses, one cycle after cmdValid
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         loadR     <= '0;
         clrR      <= '0;
         cmdReject <= 1'b0;
      end
      else
      begin
         loadR     <= loadNext;
         clrR      <= clrNext;
         cmdReject <= rejectNext;
      end
   end

   // Character controls, shared by all lines, only the loaded one looks
   always_ff @(posedge clk)
   begin
      if (|loadNext)
      begin
         abortR <= (cmdWord.charView.kind == syncTxPkg::kindAbort);
         flagR  <= (cmdWord.charView.kind == syncTxPkg::kindFlag);
         zbiR   <= cmdWord.charView.zbi;
         dataR  <= cmdWord.charView.data;
      end
   end

   ////////////////////
   // Per-line hookup
   ////////////////////

   for (genvar i = 0; i < syncTxPkg::maxLines; i++)
   begin : gLine
      if (i < numLines)
      begin : gUsed
         assign lineEmpty[i]  = lines[i].empty;
         assign lines[i].load  = loadR[i];
         assign lines[i].clr   = clrR[i];
         assign lines[i].abort = abortR;
         assign lines[i].flag  = flagR;
         assign lines[i].zbi   = zbiR;
         assign lines[i].data  = dataR;
      end
      else
      begin : gAbsent
         // Never empty, so never loaded
         assign lineEmpty[i] = 1'b0;
      end
   end

endmodule

// File: design/usrtTx.sv
// Unbuffered synchronous serial transmitter, LSB first, optional zero-bit insertion

`timescale 1ns/1ps

module usrtTx (
   input  logic    clk,
   input  logic    rst,
   input  logic    bitStrobe,
   usrtChanIf.line chan
);

   ////////////////////
   // State encoding
   ////////////////////

   localparam logic [1:0] stateIdle = 2'd0;
   localparam logic [1:0] stateSend = 2'd1;
   localparam logic [1:0] stateDone = 2'd2;

   logic [1:0] state;

   // Character being sent, bit 0 is on the line
   logic [7:0] shiftReg;

   // Data bits still to go, 8 at load
   logic [3:0] bitsLeft;

   // Consecutive ones sent in this character
   logic [2:0] onesCnt;

   // High while the inserted zero is on the line
   logic       stuffing;

   // Stuffing enable latched at load, flag and abort never stuff
   logic       txZbi;

   ////////////////////
   // Transmit FSM
   ////////////////////

   always_ff @(posedge clk)
   begin
      if (rst || chan.clr)
      begin
         // Clear drops the character mid-way, line goes back to idle
         state    <= stateIdle;
         shiftReg <= '0;
         bitsLeft <= '0;
         onesCnt  <= '0;
         stuffing <= 1'b0;
         txZbi    <= 1'b0;
      end
      else
      begin
         case (state)

            // Wait for a character
            stateIdle:
            begin
               if (chan.load)
               begin
                  // Abort wins over flag
                  if (chan.abort)
                  begin
                     shiftReg <= syncTxPkg::charAbort;
                     txZbi    <= 1'b0;
                  end
                  else if (chan.flag)
                  begin
                     shiftReg <= syncTxPkg::charFlag;
                     txZbi    <= 1'b0;
                  end
                  else
                  begin
                     shiftReg <= chan.data;
                     txZbi    <= chan.zbi;
                  end
                  bitsLeft <= 4'd8;
                  onesCnt  <= '0;
                  stuffing <= 1'b0;
                  state    <= stateSend;
               end
            end

            // One bit per strobe
            stateSend:
            begin
               if (bitStrobe)
               begin
                  if (stuffing)
                  begin
                     // Stuffed zero done, may also close the character
                     stuffing <= 1'b0;
                     if (bitsLeft == 4'd0)
                        state <= stateDone;
                  end
                  else
                  begin
                     shiftReg <= {1'b0, shiftReg[7:1]};
                     bitsLeft <= bitsLeft - 1'b1;
                     if (shiftReg[0])
                        onesCnt <= onesCnt + 1'b1;
                     else
                        onesCnt <= '0;
                     // Fifth one in a row just went out
                     if (txZbi && shiftReg[0] && (onesCnt == 3'd4))
                     begin
                        stuffing <= 1'b1;
                        onesCnt  <= '0;
                     end
                     else if (bitsLeft == 4'd1)
                        state <= stateDone;
                  end
               end
            end

            // One cycle gap before empty rises
            stateDone:
               state <= stateIdle;

            default:
               state <= stateIdle;

         endcase
      end
   end

   ////////////////////
   // Line outputs
   ////////////////////

   // Shift register is zero when idle, so txd idles low
   assign chan.txd     = shiftReg[0] & ~stuffing;
   assign chan.crcen   = ~stuffing;
   assign chan.sending = (state == stateSend);

   // Busy as soon as load arrives, blocks a second load in the same cycle
   assign chan.empty   = (state == stateIdle) & ~chan.load;

endmodule

// File: design/txCrcBank.sv
// Per-line CRC-CCITT accumulators over transmitted non-stuffed bits

`timescale 1ns/1ps

module txCrcBank #(
   parameter int numLines = 4
) (
   input  logic        clk,
   input  logic        rst,
   input  logic        bitStrobe,
   usrtChanIf.tap      lines [numLines],
   output logic [15:0] crc [numLines]
);

   ////////////////////
   // One accumulator per line
   ////////////////////

   for (genvar i = 0; i < numLines; i++)
   begin : gCrc

      logic        bitTake;
      logic        feedBack;
      logic [15:0] crcNext;

      // Bit counts only while the character is on the line and not stuffed
      assign bitTake = bitStrobe & lines[i].sending & lines[i].crcen;

      // MSB-first shift of the bits in the order they hit the wire
      assign feedBack = crc[i][15] ^ lines[i].txd;

      always_comb
      begin
         if (feedBack)
            crcNext = {crc[i][14:0], 1'b0} ^ syncTxPkg::crcPoly;
         else
            crcNext = {crc[i][14:0], 1'b0};
      end

      always_ff @(posedge clk)
      begin
         if (rst || lines[i].clr)
            crc[i] <= syncTxPkg::crcInit;
         else if (bitTake)
            crc[i] <= crcNext;
      end

   end

endmodule

// File: design/syncTxTop.sv
// Top level: channel interfaces, dispatcher, transmitter array and CRC bank

`timescale 1ns/1ps

module syncTxTop #(
   parameter int numLines = 4,
   parameter int clkDiv   = 4
) (
   input  logic                clk,
   input  logic                rst,
   input  logic                cmdValid,
   input  logic [15:0]         cmdWord,
   output logic                bitStrobe,
   output logic [numLines-1:0] txd,
   output logic [numLines-1:0] empty,
   output logic                cmdReject,
   output logic [15:0]         crc [numLines]
);

   ////////////////////
   // Channels
   ////////////////////

   // One bundle per line
   usrtChanIf chanIf [numLines] ();

   // Strobe and commands, plain bits become the command union here
   txDispatch #(
      .numLines (numLines),
      .clkDiv   (clkDiv)
   ) uDispatch (
      .clk       (clk),
      .rst       (rst),
      .cmdValid  (cmdValid),
      .cmdWord   (cmdWord),
      .bitStrobe (bitStrobe),
      .cmdReject (cmdReject),
      .lines     (chanIf)
   );

   ////////////////////
   // Transmitters
   ////////////////////

   for (genvar i = 0; i < numLines; i++)
   begin : gTx
      usrtTx uTx (
         .clk       (clk),
         .rst       (rst),
         .bitStrobe (bitStrobe),
         .chan      (chanIf[i])
      );

      // Serial data and status out to plain ports
      assign txd[i]   = chanIf[i].txd;
      assign empty[i] = chanIf[i].empty;
   end

   // Check values, one per line
   txCrcBank #(
      .numLines (numLines)
   ) uCrc (
      .clk       (clk),
      .rst       (rst),
      .bitStrobe (bitStrobe),
      .lines     (chanIf),
      .crc       (crc)
   );

endmodule

// File: bench/syncTxBench.sv
// Testbench for syncTxTop with clock, reset, command driver, serial line model, checker and watchdog

`timescale 1ns/1ps

module syncTxBench;

   localparam int numLines  = 4;
   localparam int clkDiv    = 4;
   localparam int clkPeriod = 40;
   localparam int recWords  = 7;
   localparam int maxRecs   = 64;

   // DUT ports
   logic                clk = 1'b0;
   logic                rst;
   logic                cmdValid;
   logic [15:0]         cmdWord;
   logic                bitStrobe;
   logic [numLines-1:0] txd;
   logic [numLines-1:0] empty;
   logic                cmdReject;
   logic [15:0]         crc [numLines];

   // Records of cmd, reject, wait mask, four CRCs
   logic [15:0] stim [0:maxRecs*recWords-1];
   int          recCount = 0;
   int          cycle = 0;
   int          rstCycle;

   ////////////////////
   // Line model state
   ////////////////////

   logic        busy     [numLines];
   logic [15:0] bitPat   [numLines];   // Bits as they go on the wire, stuffing included
   int          bitLen   [numLines];
   int          bitPos   [numLines];
   int          busyFrom [numLines];   // Load cycle, empty drops here
   int          startAt  [numLines];   // First cycle bit 0 is on txd
   int          freeAt   [numLines];
   int          clearAt  [numLines];   // Cycle of the clr pulse

   syncTxTop #(
      .numLines (numLines),
      .clkDiv   (clkDiv)
   ) dut (
      .clk       (clk),
      .rst       (rst),
      .cmdValid  (cmdValid),
      .cmdWord   (cmdWord),
      .bitStrobe (bitStrobe),
      .txd       (txd),
      .empty     (empty),
      .cmdReject (cmdReject),
      .crc       (crc)
   );

   always #(clkPeriod / 2) clk = ~clk;

   // Cycle number as seen by driver and monitor after the rising edge
   always @(posedge clk)
      cycle <= cycle + 1;

   task automatic checkValue(input string name, input logic [15:0] expected,
                             input logic [15:0] actual);
      if (actual !== expected)
      begin
         $display("MISMATCH at %0t ns: %s expected %0h actual %0h",
                  $time, name, expected, actual);
         $display("Regression failed");
         $fatal(1, "stopped at first error");
      end
   endtask

   // Expected wire bits for one character with a zero after every fifth one
   task automatic armLine(input int l, input logic [7:0] ch, input logic stuff, input int n0);
      int          ones;
      int          len;
      logic [15:0] pat;
      ones = 0;
      len  = 0;
      pat  = '0;
      for (int b = 0; b < 8; b++)
      begin
         pat[len] = ch[b];
         len++;
         if (ch[b])
            ones++;
         else
            ones = 0;
         if (stuff && ones == 5)
         begin
            pat[len] = 1'b0;
            len++;
            ones = 0;
         end
      end
      bitPat[l]   = pat;
      bitLen[l]   = len;
      bitPos[l]   = 0;
      busyFrom[l] = n0 + 1;
      startAt[l]  = n0 + 2;
      busy[l]     = 1'b1;
   endtask

   // Check txd and empty of one line for one cycle and advance on a strobe
   task automatic watchLine(input int l);
      logic expTxd;
      logic expEmpty;
      logic bitsLeft;
      expTxd   = 1'b0;
      expEmpty = 1'b1;
      bitsLeft = (bitPos[l] < bitLen[l]);
      if (busy[l] && cycle >= busyFrom[l])
      begin
         expEmpty = 1'b0;
         if (bitsLeft && cycle >= startAt[l])
            expTxd = bitPat[l][bitPos[l]];
         else if (!bitsLeft && cycle >= freeAt[l])
         begin
            busy[l]  = 1'b0;
            expEmpty = 1'b1;
         end
      end
      checkValue($sformatf("txd[%0d]", l), expTxd, txd[l]);
      checkValue($sformatf("empty[%0d]", l), expEmpty, empty[l]);
      if (busy[l] && bitsLeft && cycle >= startAt[l] && bitStrobe)
      begin
         bitPos[l]++;
         // One cycle in the done state before idle
         if (bitPos[l] == bitLen[l])
            freeAt[l] = cycle + 2;
      end
      if (cycle == clearAt[l])
      begin
         busy[l]   = 1'b0;
         bitPos[l] = bitLen[l];
      end
   endtask

   ////////////////////
   // Monitor
   ////////////////////

   // Sample mid-cycle where outputs have settled
   always @(negedge clk)
   begin
      if (!rst)
      begin
         checkValue("bitStrobe", ((cycle - rstCycle) % clkDiv) == clkDiv - 1, bitStrobe);
         for (int l = 0; l < numLines; l++)
            watchLine(l);
      end
   end

   // Drive one record, check reject, optionally wait and check CRCs
   task automatic runCommand(input int r);
      syncTxPkg::txCommand cmd;
      logic [15:0]         word;
      logic                expReject;
      logic [3:0]          waitMask;
      int                  n0;
      int                  l;
      word      = stim[r*recWords];
      expReject = stim[r*recWords+1][0];
      waitMask  = stim[r*recWords+2][3:0];
      cmd       = word;
      @(posedge clk);
      #2;
      cmdValid = 1'b1;
      cmdWord  = word;
      n0       = cycle;
      l        = cmd.charView.chan;
      if (cmd.charView.op == syncTxPkg::opChar && !expReject)
      begin
         // Flag and abort never stuff
         case (cmd.charView.kind)
            syncTxPkg::kindFlag:  armLine(l, syncTxPkg::charFlag, 1'b0, n0);
            syncTxPkg::kindAbort: armLine(l, syncTxPkg::charAbort, 1'b0, n0);
            default:              armLine(l, cmd.charView.data, cmd.charView.zbi, n0);
         endcase
      end
      else if (cmd.ctrlView.op == syncTxPkg::opClear)
      begin
         for (int i = 0; i < numLines; i++)
            if (cmd.ctrlView.clearMask[i])
               clearAt[i] = n0 + 1;
      end
      @(posedge clk);
      #2;
      cmdValid = 1'b0;
      checkValue("cmdReject", expReject, cmdReject);
      // Load and clr pulses act on the edge that ends their cycle
      @(posedge clk);
      #2;
      while ((empty & waitMask) != waitMask)
      begin
         @(posedge clk);
         #2;
      end
      for (int i = 0; i < numLines; i++)
         if (waitMask[i])
            checkValue($sformatf("crc[%0d]", i), stim[r*recWords+3+i], crc[i]);
      // Idle gap before the next command
      repeat ($urandom % 8) @(posedge clk);
   endtask

   ////////////////////
   // Main sequence
   ////////////////////

   initial
   begin
      void'($urandom(49453));
      rst      = 1'b1;
      cmdValid = 1'b0;
      cmdWord  = '0;
      rstCycle = 0;
      for (int l = 0; l < numLines; l++)
      begin
         busy[l]     = 1'b0;
         bitPat[l]   = '0;
         bitLen[l]   = 0;
         bitPos[l]   = 0;
         busyFrom[l] = 0;
         startAt[l]  = 0;
         freeAt[l]   = 0;
         clearAt[l]  = -1;
      end
      $readmemh("bench/txCmdInput.dat", stim);
      // List ends at command word FFFF
      while (recCount < maxRecs && stim[recCount*recWords] !== 16'hFFFF)
         recCount++;
      if (recCount == 0 || recCount == maxRecs)
      begin
         $display("Stimulus file is missing, empty or has no end marker");
         $display("Regression failed");
         $fatal(1, "no usable stimulus");
      end
      repeat (3) @(posedge clk);
      #2;
      rst      = 1'b0;
      rstCycle = cycle;
      for (int r = 0; r < recCount; r++)
         runCommand(r);
      repeat (2 * clkDiv) @(posedge clk);
      $display("Regression passed");
      $finish;
   end

   // About twelve bit times per command plus gap and reset margin
   initial
   begin
      wait (rst === 1'b0);
      #((recCount * (12 * clkDiv + 8) + 100) * clkPeriod);
      $display("Watchdog expired, the run hung before the command list finished");
      $display("Regression failed");
      $fatal(1, "watchdog timeout");
   end

endmodule

// File: bench/txCmdInput.dat
// cmd rej wait crc0 crc1 crc2 crc3, all hex
// crcN checked only where wait mask bit N is set, cmd FFFF ends the list
// Plain data on every line
4F00 0 F FFFF FFFF FFFF FFFF
00A5 0 0 0000 0000 0000 0000
103C 0 0 0000 0000 0000 0000
2081 0 0 0000 0000 0000 0000
305A 0 F 04BF 162F 6059 1A4F
// Stuffed on line 0, unstuffed on line 1, same check value
4F00 0 F FFFF FFFF FFFF FFFF
02FF 0 0 0000 0000 0000 0000
10FF 0 3 FF00 FF00 0000 0000
023E 0 0 0000 0000 0000 0000
103E 0 3 A1EB A1EB 0000 0000
// Abort and flag with zbi set
2A12 0 0 0000 0000 0000 0000
3634 0 C 0000 0000 FF00 7EA9
2634 0 4 0000 0000 81A9 0000
// Busy line rejects
4100 0 1 FFFF 0000 0000 0000
00A5 0 0 0000 0000 0000 0000
005A 1 0 0000 0000 0000 0000
02C3 1 1 04BF 0000 0000 0000
// Clear lines 1 and 2 mid-character, line 3 runs on
4E00 0 E 0000 FFFF FFFF FFFF
12FF 0 0 0000 0000 0000 0000
20F0 0 0 0000 0000 0000 0000
305A 0 0 0000 0000 0000 0000
4600 0 6 0000 FFFF FFFF 0000
8000 0 8 0000 0000 0000 1A4F
FFFF 0 0 0000 0000 0000 0000

// File: flist.f
design/syncTxPkg.sv
design/usrtChanIf.sv
design/txDispatch.sv
design/usrtTx.sv
design/txCrcBank.sv
design/syncTxTop.sv
bench/syncTxBench.sv

// File: Bender.yml
package:
  name: sync_tx

sources:
  # Design, in compile order
  - design/syncTxPkg.sv
  - design/usrtChanIf.sv
  - design/txDispatch.sv
  - design/usrtTx.sv
  - design/txCrcBank.sv
  - design/syncTxTop.sv

  # Testbench
  - target: simulation
    files:
      - bench/syncTxBench.sv

# Simulation top is syncTxBench, design top is syncTxTop
# Stimulus file bench/txCmdInput.dat is read from the project root
